/* sources.f */
+incdir+verilog
verilog/alu_pkg.sv
verilog/polar_pkg.sv
verilog/polar_lane_dispatch.sv
verilog/polar_lane.sv
verilog/scalar_alu.sv
verilog/alu_result_stage.sv
verilog/polar_alu_top.sv
test/tb_clock_gen.sv
test/tb_polar_alu.sv

/* test/tb_polar_alu.sv */
`timescale 1ns/1ps

`include "alu_config.svh"

module tb_polar_alu;

    import alu_pkg::*;
    import polar_pkg::*;

    localparam int W            = `ALU_LANE_W;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int SCALAR_N     = 200;
    localparam int BRANCH_N     = 60;
    localparam int SAT_N        = 150;
    localparam int MISC_N       = 100;
    localparam int STREAM_N     = 200;
    // Streaming may add one idle cycle per request
    localparam int NUM_TESTS    = SCALAR_N + BRANCH_N + SAT_N + MISC_N + 2 * STREAM_N;

    logic      clk;
    logic      reset_i;
    logic      valid_i;
    alu_req_t  req_i;
    logic      valid_o;
    alu_resp_t resp_o;

    integer    seed;
    logic      monitor_on = 1'b0;
    logic      valid_d = 1'b0;
    alu_resp_t last_resp = '0;
    alu_resp_t exp_q[$];

    alu_op_e scalar_ops[10] = '{ADD, SUB, ANDL, ORL, XORL, ANDN, ORN, XNOR, SLTS, SLTU};
    alu_op_e branch_ops[6]  = '{EQ, NE, LTS, LTU, GES, GEU};
    alu_op_e sat_ops[3]     = '{PL_ADDSAT, PL_SUBSAT, PL_F};
    alu_op_e misc_ops[3]    = '{PL_R, PL_DECODE, PL_EVAL};

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) tb_clock_gen_i (.clk_o(clk));

    polar_alu_top polar_alu_top_i (
        .clk_i   (clk),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .req_i   (req_i),
        .valid_o (valid_o),
        .resp_o  (resp_o)
    );

    // ------------------------------
    // Failure reporting and compares
    // ------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp)
            report_failure($sformatf("FAIL %0t ns %s expected %h actual %h",
                                     $time, name, exp, act));
    endtask

    task automatic check_branch(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("FAIL %0t ns %s expected %b actual %b",
                                     $time, name, exp, act));
    endtask

    task automatic check_valid(input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("FAIL %0t ns valid_o expected %b actual %b",
                                     $time, exp, act));
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic int saturate(input int value);
        if (value > `ALU_SAT_MAX)
            return `ALU_SAT_MAX;
        if (value < -`ALU_SAT_MAX)
            return -`ALU_SAT_MAX;
        return value;
    endfunction

    function automatic lane_byte_t lane_model(input polar_op_e op, input lane_byte_t a,
                                              input lane_byte_t b, input lane_byte_t b_low);
        int sa;
        int sb;
        int mag_a;
        int mag_b;
        int mag;
        int val;
        sa    = $signed(a);
        sb    = $signed(b);
        // Magnitude of -128 is 128, which truncates back to 8'h80
        mag_a = (sa < 0) ? -sa : sa;
        mag_b = (sb < 0) ? -sb : sb;
        mag   = (mag_b < mag_a) ? mag_b : mag_a;
        case (op)
            R:       val = (b_low == 8'd1) ? 0 : ((sa < 0) ? 1 : 0);
            F:       val = ((sa < 0) != (sb < 0)) ? -mag : mag;
            ADDSAT:  val = saturate(sa + sb);
            SUBSAT:  val = saturate(sa - sb);
            DECODE:  val = (b_low == 8'd0) ? sa : 0;
            EVAL:    val = (sa == 1) ? 255 : 0;
            default: val = 0;
        endcase
        return lane_byte_t'(val);
    endfunction

    function automatic alu_resp_t model_resp(input alu_req_t req);
        alu_resp_t resp;
        xlen_t     a;
        xlen_t     b;
        polar_op_e lop;
        a                 = req.operand_a;
        b                 = req.operand_b;
        resp.result       = '0;
        resp.branch_taken = 1'b1;
        lop               = PL_NONE;
        case (req.operator)
            ADD:       resp.result = a + b;
            SUB:       resp.result = a - b;
            ANDL:      resp.result = a & b;
            ORL:       resp.result = a | b;
            XORL:      resp.result = a ^ b;
            ANDN:      resp.result = a & ~b;
            ORN:       resp.result = a | ~b;
            XNOR:      resp.result = a ^ ~b;
            SLTS:      resp.result = xlen_t'($signed(a) < $signed(b));
            SLTU:      resp.result = xlen_t'(a < b);
            EQ:        resp.branch_taken = (a == b);
            NE:        resp.branch_taken = (a != b);
            LTS:       resp.branch_taken = ($signed(a) < $signed(b));
            LTU:       resp.branch_taken = (a < b);
            GES:       resp.branch_taken = ($signed(a) >= $signed(b));
            GEU:       resp.branch_taken = (a >= b);
            PL_R:      lop = R;
            PL_F:      lop = F;
            PL_ADDSAT: lop = ADDSAT;
            PL_SUBSAT: lop = SUBSAT;
            PL_DECODE: lop = DECODE;
            PL_EVAL:   lop = EVAL;
            default:   ;
        endcase
        if (lop != PL_NONE) begin
            for (int i = 0; i < `ALU_LANES; i++)
                resp.result[i*W +: W] = lane_model(lop, a[i*W +: W], b[i*W +: W], b[W-1:0]);
        end
        return resp;
    endfunction

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    // Biased toward sign boundaries
    function automatic xlen_t rand_word();
        case ($unsigned($random(seed)) % 8)
            0:       return '0;
            1:       return 64'h1;
            2:       return '1;
            3:       return 64'h8000_0000_0000_0000;
            4:       return 64'h7fff_ffff_ffff_ffff;
            default: return {$random(seed), $random(seed)};
        endcase
    endfunction

    function automatic lane_byte_t rand_lane_byte();
        case ($unsigned($random(seed)) % 8)
            0:       return 8'h80;
            1:       return 8'h81;
            2:       return 8'h7f;
            3:       return 8'h01;
            4:       return 8'hff;
            default: return lane_byte_t'($random(seed));
        endcase
    endfunction

    function automatic xlen_t rand_lanes();
        xlen_t word;
        for (int i = 0; i < `ALU_LANES; i++)
            word[i*W +: W] = rand_lane_byte();
        return word;
    endfunction

    task automatic drive_req(input alu_op_e op, input xlen_t a, input xlen_t b);
        alu_req_t req;
        req.operator  = op;
        req.operand_a = a;
        req.operand_b = b;
        @(negedge clk);
        valid_i = 1'b1;
        req_i   = req;
        exp_q.push_back(model_resp(req));
    endtask

    task automatic drive_idle();
        alu_req_t req;
        req.operator  = alu_op_e'($unsigned($random(seed)) % 23);
        req.operand_a = rand_word();
        req.operand_b = rand_word();
        @(negedge clk);
        valid_i = 1'b0;
        // Idle cycles carry fresh operands that must not reach resp_o
        req_i   = req;
    endtask

    // Expected valid_o trails valid_i by one cycle
    always @(posedge clk) begin
        valid_d <= reset_i ? 1'b0 : valid_i;
    end

    // Outputs are stable mid-cycle
    always @(negedge clk) begin : monitor
        alu_resp_t exp_resp;
        if (monitor_on) begin
            check_valid(valid_d, valid_o);
            if (valid_o) begin
                if (exp_q.size() == 0) begin
                    report_failure("valid_o went high with no request outstanding");
                end else begin
                    exp_resp = exp_q.pop_front();
                    check_result("resp_o.result", exp_resp.result, resp_o.result);
                    check_branch("resp_o.branch_taken", exp_resp.branch_taken,
                                 resp_o.branch_taken);
                    last_resp = exp_resp;
                end
            end else begin
                // Last result stays on resp_o while idle
                check_result("resp_o.result", last_resp.result, resp_o.result);
                check_branch("resp_o.branch_taken", last_resp.branch_taken,
                             resp_o.branch_taken);
            end
        end
    end

    initial begin : watchdog
        #((RESET_CYCLES + NUM_TESTS + 20) * CLK_PERIOD);
        report_failure("Timeout, results stopped arriving from the DUT");
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin : main
        xlen_t   a;
        xlen_t   b;
        alu_op_e op;
        seed    = 32'he2f1;
        reset_i = 1'b1;
        valid_i = 1'b0;
        req_i   = '0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_valid(1'b0, valid_o);
            check_result("resp_o.result", '0, resp_o.result);
            check_branch("resp_o.branch_taken", 1'b0, resp_o.branch_taken);
        end
        reset_i = 1'b0;
        @(negedge clk);
        check_valid(1'b0, valid_o);
        check_result("resp_o.result", '0, resp_o.result);
        check_branch("resp_o.branch_taken", 1'b0, resp_o.branch_taken);
        monitor_on = 1'b1;

        // Scalar arithmetic and logic
        repeat (SCALAR_N)
            drive_req(scalar_ops[$unsigned($random(seed)) % 10], rand_word(), rand_word());

        // Branch compares with equal, negative and large unsigned operands
        repeat (BRANCH_N) begin
            a = rand_word();
            b = rand_word();
            case ($unsigned($random(seed)) % 3)
                0:       b = a;
                1:       a[63] = 1'b1;
                default: begin
                    a[63] = 1'b1;
                    b[63] = 1'b1;
                end
            endcase
            drive_req(branch_ops[$unsigned($random(seed)) % 6], a, b);
        end

        // Saturation, F ties and -128
        repeat (SAT_N)
            drive_req(sat_ops[$unsigned($random(seed)) % 3], rand_lanes(), rand_lanes());

        // R, DECODE and EVAL with the low byte of b forced
        repeat (MISC_N) begin
            b = rand_lanes();
            case ($unsigned($random(seed)) % 3)
                0:       b[W-1:0] = 8'd0;
                1:       b[W-1:0] = 8'd1;
                default: ;
            endcase
            drive_req(misc_ops[$unsigned($random(seed)) % 3], rand_lanes(), b);
        end

        // Mixed stream with idle gaps
        repeat (STREAM_N) begin
            op = alu_op_e'($unsigned($random(seed)) % 23);
            if (op >= PL_R && op <= PL_EVAL)
                drive_req(op, rand_lanes(), rand_lanes());
            else
                drive_req(op, rand_word(), rand_word());
            if ($unsigned($random(seed)) % 3 == 0)
                drive_idle();
        end

        drive_idle();
        repeat (3) @(negedge clk);
        if (exp_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            report_failure("Some requests never produced a result");
        end
    end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    // Free running, starts low
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

/* verilog/polar_alu_top.sv */
`timescale 1ns/1ps

`include "alu_config.svh"

module polar_alu_top (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 valid_i,
    input  alu_pkg::alu_req_t    req_i,
    output logic                 valid_o,
    output alu_pkg::alu_resp_t   resp_o
);

    import alu_pkg::*;
    import polar_pkg::*;

    lane_req_vec_t lane_reqs;
    polar_op_e     lane_op;
    logic          polar_sel;
    lane_res_vec_t lane_res;
    alu_resp_t     scalar_resp;

    // ------------------------------
    // Polar SIMD path
    // ------------------------------
    polar_lane_dispatch polar_lane_dispatch_i (
        .req_i       (req_i),
        .lanes_o     (lane_reqs),
        .lane_op_o   (lane_op),
        .polar_sel_o (polar_sel)
    );

    for (genvar i = 0; i < `ALU_LANES; i++) begin : gen_lanes
        polar_lane polar_lane_i (
            .lane_i (lane_reqs[i]),
            .op_i   (lane_op),
            .res_o  (lane_res[i])
        );
    end

    // Scalar path runs in parallel
    scalar_alu scalar_alu_i (
        .req_i  (req_i),
        .resp_o (scalar_resp)
    );

    alu_result_stage alu_result_stage_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .valid_i     (valid_i),
        .polar_sel_i (polar_sel),
        .lanes_i     (lane_res),
        .scalar_i    (scalar_resp),
        .valid_o     (valid_o),
        .resp_o      (resp_o)
    );

endmodule

/* verilog/alu_result_stage.sv */
`timescale 1ns/1ps

`include "alu_config.svh"

module alu_result_stage (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      valid_i,
    input  logic                      polar_sel_i,
    input  polar_pkg::lane_res_vec_t  lanes_i,
    input  alu_pkg::alu_resp_t        scalar_i,
    output logic                      valid_o,
    output alu_pkg::alu_resp_t        resp_o
);

    import alu_pkg::*;

    localparam int W = `ALU_LANE_W;

    xlen_t     lane_word;
    alu_resp_t next_resp;

    // Lane 0 lands in the low byte
    always_comb begin
        for (int i = 0; i < `ALU_LANES; i++) begin
            lane_word[i*W +: W] = lanes_i[i];
        end
    end

    // Polar ops always report a taken branch
    always_comb begin
        if (polar_sel_i) begin
            next_resp.result       = lane_word;
            next_resp.branch_taken = 1'b1;
        end else begin
            next_resp = scalar_i;
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            resp_o  <= '0;
        end else begin
            valid_o <= valid_i;
            // Hold the last result across idle cycles
            if (valid_i) begin
                resp_o <= next_resp;
            end
        end
    end

endmodule

/* verilog/scalar_alu.sv */
`timescale 1ns/1ps

`include "alu_config.svh"

module scalar_alu (
    input  alu_pkg::alu_req_t   req_i,
    output alu_pkg::alu_resp_t  resp_o
);

    import alu_pkg::*;

    logic                 b_negate;
    logic [`ALU_XLEN:0]   adder_in_a;
    logic [`ALU_XLEN:0]   adder_in_b;
    logic [`ALU_XLEN:0]   adder_sum;
    xlen_t                adder_res;
    xlen_t                operand_b_mod;
    logic                 zero_flag;
    logic                 cmp_signed;
    logic                 less;

    // ------------------------------
    // Adder
    // ------------------------------
    always_comb begin
        case (req_i.operator)
            SUB, EQ, NE, ANDN, ORN, XNOR: b_negate = 1'b1;
            default:                      b_negate = 1'b0;
        endcase
    end

    // Extra low bit carries the +1 of the two's complement
    assign adder_in_a = {req_i.operand_a, 1'b1};
    assign adder_in_b = {req_i.operand_b, 1'b0} ^ {(`ALU_XLEN+1){b_negate}};
    assign adder_sum  = adder_in_a + adder_in_b;
    assign adder_res  = adder_sum[`ALU_XLEN:1];
    assign zero_flag  = ~|adder_res;

    // Inverted b feeds the N logic forms
    assign operand_b_mod = adder_in_b[`ALU_XLEN:1];

    // ------------------------------
    // Comparator
    // ------------------------------
    assign cmp_signed = (req_i.operator == SLTS) || (req_i.operator == LTS) ||
                        (req_i.operator == GES);

    assign less = $signed({cmp_signed & req_i.operand_a[`ALU_XLEN-1], req_i.operand_a}) <
                  $signed({cmp_signed & req_i.operand_b[`ALU_XLEN-1], req_i.operand_b});

    // ------------------------------
    // Result and branch select
    // ------------------------------
    always_comb begin
        case (req_i.operator)
            ADD, SUB:    resp_o.result = adder_res;
            ANDL, ANDN:  resp_o.result = req_i.operand_a & operand_b_mod;
            ORL, ORN:    resp_o.result = req_i.operand_a | operand_b_mod;
            XORL, XNOR:  resp_o.result = req_i.operand_a ^ operand_b_mod;
            SLTS, SLTU:  resp_o.result = xlen_t'(less);
            default:     resp_o.result = '0;
        endcase

        case (req_i.operator)
            EQ:         resp_o.branch_taken = zero_flag;
            NE:         resp_o.branch_taken = ~zero_flag;
            LTS, LTU:   resp_o.branch_taken = less;
            GES, GEU:   resp_o.branch_taken = ~less;
            default:    resp_o.branch_taken = 1'b1;
        endcase
    end

endmodule

/* verilog/polar_lane.sv */
`timescale 1ns/1ps

`include "alu_config.svh"

module polar_lane (
    input  polar_pkg::lane_req_t   lane_i,
    input  polar_pkg::polar_op_e   op_i,
    output polar_pkg::lane_byte_t  res_o
);

    import polar_pkg::*;

    localparam int W = `ALU_LANE_W;
    localparam logic signed [W:0] SAT_HI = `ALU_SAT_MAX;
    localparam logic signed [W:0] SAT_LO = -`ALU_SAT_MAX;

    logic              sign_bit;
    lane_byte_t        abs_a;
    lane_byte_t        abs_b;
    lane_byte_t        f_mag;
    logic signed [W:0] sum9;
    logic signed [W:0] diff9;
    lane_byte_t        r_val;
    lane_byte_t        f_val;
    lane_byte_t        addsat_val;
    lane_byte_t        subsat_val;
    lane_byte_t        decode_val;
    lane_byte_t        eval_val;

    // ------------------------------
    // Magnitude and sign
    // ------------------------------
    assign sign_bit = lane_i.a[W-1] ^ lane_i.b[W-1];

    // -128 wraps back onto itself
    assign abs_a = lane_i.a[W-1] ? -lane_i.a : lane_i.a;
    assign abs_b = lane_i.b[W-1] ? -lane_i.b : lane_i.b;

    // Unsigned compare treats 8'h80 as the largest magnitude
    assign f_mag = (abs_a > abs_b) ? abs_b : abs_a;
    assign f_val = sign_bit ? -f_mag : f_mag;

    // Hard decision is forced to 0 on frozen bits
    assign r_val = (lane_i.frozen_bit || !lane_i.a[W-1]) ? lane_byte_t'(0) : lane_byte_t'(1);

    // ------------------------------
    // Saturating add and subtract
    // ------------------------------
    assign sum9  = $signed(lane_i.a) + $signed(lane_i.b);
    assign diff9 = $signed(lane_i.a) - $signed(lane_i.b);

    assign addsat_val = (sum9 > SAT_HI)  ? SAT_HI[W-1:0] :
                        (sum9 < SAT_LO)  ? SAT_LO[W-1:0] : sum9[W-1:0];
    assign subsat_val = (diff9 > SAT_HI) ? SAT_HI[W-1:0] :
                        (diff9 < SAT_LO) ? SAT_LO[W-1:0] : diff9[W-1:0];

    assign decode_val = lane_i.zero_bit ? lane_i.a : lane_byte_t'(0);
    assign eval_val   = (lane_i.a == lane_byte_t'(1)) ? '1 : '0;

    always_comb begin
        case (op_i)
            R:       res_o = r_val;
            F:       res_o = f_val;
            ADDSAT:  res_o = addsat_val;
            SUBSAT:  res_o = subsat_val;
            DECODE:  res_o = decode_val;
            EVAL:    res_o = eval_val;
            default: res_o = '0;
        endcase
    end

endmodule

/* verilog/polar_lane_dispatch.sv */
`timescale 1ns/1ps

`include "alu_config.svh"

module polar_lane_dispatch (
    input  alu_pkg::alu_req_t          req_i,
    output polar_pkg::lane_req_vec_t   lanes_o,
    output polar_pkg::polar_op_e       lane_op_o,
    output logic                       polar_sel_o
);

    import alu_pkg::*;
    import polar_pkg::*;

    localparam int W = `ALU_LANE_W;

    logic frozen_bit;
    logic zero_bit;

    // ------------------------------
    // Opcode translation
    // ------------------------------
    always_comb begin
        case (req_i.operator)
            PL_R:      lane_op_o = R;
            PL_F:      lane_op_o = F;
            PL_ADDSAT: lane_op_o = ADDSAT;
            PL_SUBSAT: lane_op_o = SUBSAT;
            PL_DECODE: lane_op_o = DECODE;
            PL_EVAL:   lane_op_o = EVAL;
            // Scalar operators leave the lanes idle
            default:   lane_op_o = PL_NONE;
        endcase
    end

    assign polar_sel_o = (lane_op_o != PL_NONE);

    // Flags computed once and fanned out to every lane
    assign frozen_bit = (req_i.operand_b[W-1:0] == lane_byte_t'(1));
    assign zero_bit   = (req_i.operand_b[W-1:0] == lane_byte_t'(0));

    // ------------------------------
    // Operand slicing
    // ------------------------------
    always_comb begin
        for (int i = 0; i < `ALU_LANES; i++) begin
            lanes_o[i].a          = req_i.operand_a[i*W +: W];
            lanes_o[i].b          = req_i.operand_b[i*W +: W];
            lanes_o[i].frozen_bit = frozen_bit;
            lanes_o[i].zero_bit   = zero_bit;
        end
    end

endmodule

/* verilog/polar_pkg.sv */
`include "alu_config.svh"

package polar_pkg;

    // One signed lane value
    typedef logic [`ALU_LANE_W-1:0] lane_byte_t;

    // ------------------------------
    // Lane function select
    // ------------------------------
    typedef enum logic [2:0] {
        PL_NONE,
        R,
        F,
        ADDSAT,
        SUBSAT,
        DECODE,
        EVAL
    } polar_op_e;

    // Operands seen by a single lane
    typedef struct packed {
        lane_byte_t a;
        lane_byte_t b;
        // Shared flags from the low byte of operand b
        logic       frozen_bit;
        logic       zero_bit;
    } lane_req_t;

    // Lane 0 sits at index 0
    typedef lane_req_t [`ALU_LANES-1:0] lane_req_vec_t;

    typedef lane_byte_t [`ALU_LANES-1:0] lane_res_vec_t;

endpackage

/* verilog/alu_pkg.sv */
`include "alu_config.svh"

package alu_pkg;

    // One scalar data word
    typedef logic [`ALU_XLEN-1:0] xlen_t;

    // ------------------------------
    // Operator encoding
    // ------------------------------
    typedef enum logic [5:0] {
        ADD,
        SUB,
        // Plain logic
        ANDL,
        ORL,
        XORL,
        // Logic with inverted operand b
        ANDN,
        ORN,
        XNOR,
        // Set-less-than
        SLTS,
        SLTU,
        // Branch compares
        EQ,
        NE,
        LTS,
        LTU,
        GES,
        GEU,
        // Polar SIMD lane operations
        PL_R,
        PL_F,
        PL_ADDSAT,
        PL_SUBSAT,
        PL_DECODE,
        PL_EVAL,
        NOP
    } alu_op_e;

    // Request into the ALU
    typedef struct packed {
        alu_op_e operator;
        xlen_t   operand_a;
        xlen_t   operand_b;
    } alu_req_t;

    // Result word plus branch decision
    typedef struct packed {
        xlen_t result;
        logic  branch_taken;
    } alu_resp_t;

endpackage

/* verilog/alu_config.svh */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// ------------------------------
// Datapath geometry
// ------------------------------

// Full scalar data word
`define ALU_XLEN 64

// One polar lane holds a signed byte
`define ALU_LANE_W 8

// SIMD lanes across the data word
`define ALU_LANES 8

// ------------------------------
// Polar arithmetic limits
// ------------------------------

// Symmetric clamp keeps -128 out of ADDSAT and SUBSAT results
`define ALU_SAT_MAX 127

`endif
